// ==== verilog/ssc_defs.svh ====
/* size macros for the snack-shopping calculator
   digit and item counts, nibble width, money and sum widths */
`ifndef SSC_DEFS_SVH
`define SSC_DEFS_SVH

// ========================================
// transaction format
// ========================================

// digits in one card number, position 1 is the lowest nibble
`define SSC_CARD_DIGITS 16

// snack kinds per transaction
`define SSC_ITEMS 8

// one card digit, one snack count, one unit price
`define SSC_NIBBLE 4

// ========================================
// arithmetic widths
// ========================================

// input money and the returned change
`define SSC_MONEY_W 9

// count times price, at most 15 * 15
`define SSC_TOTAL_W 8

// running sum of eight totals, at most 8 * 225
`define SSC_SUM_W 11

// card is good when the digit sum is a multiple of this
`define SSC_LUHN_MOD 10

`endif

// ==== verilog/ssc_card_pkg.sv ====
/* card number types used by the Luhn check */
`include "ssc_defs.svh"

package ssc_card_pkg;

    // ========================================
    // card digits
    // ========================================

    // one digit of the card number
    typedef logic [`SSC_NIBBLE-1:0] digit_t;

    // all sixteen digits, index 0 holds position 1
    typedef digit_t card_digits_t [`SSC_CARD_DIGITS];

    // ========================================
    // check sum
    // ========================================

    // sixteen reduced digits of at most 15 each
    // max 240, so eight bits hold it
    typedef logic [7:0] luhn_sum_t;

endpackage

// ==== verilog/ssc_order_pkg.sv ====
/* order types: money, counts, prices, item totals,
   sorted basket and running sums */
`include "ssc_defs.svh"

package ssc_order_pkg;

    // ========================================
    // transaction fields
    // ========================================

    // input money and the change handed back
    typedef logic [`SSC_MONEY_W-1:0] money_t;

    // one snack count or one unit price
    typedef logic [`SSC_NIBBLE-1:0] nibble_t;

    // ========================================
    // derived values
    // ========================================

    // count times price for one snack kind
    typedef logic [`SSC_TOTAL_W-1:0] item_total_t;

    // all item totals of one transaction
    // after the sorter, index 0 is the largest
    typedef item_total_t basket_t [`SSC_ITEMS];

    // running sum over the sorted basket
    // wide enough for all eight totals at 225 each
    typedef logic [`SSC_SUM_W-1:0] prefix_sum_t;

endpackage

// ==== verilog/card_intake.sv ====
/* stage one: Luhn check of the card number,
   registers the verdict, money, counts and prices */
`include "ssc_defs.svh"

module card_intake (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    in_valid,
    input  logic [`SSC_CARD_DIGITS*`SSC_NIBBLE-1:0] card_num,
    input  ssc_order_pkg::money_t                   input_money,
    input  logic [`SSC_ITEMS*`SSC_NIBBLE-1:0]       snack_num,
    input  logic [`SSC_ITEMS*`SSC_NIBBLE-1:0]       price,
    output logic                                    s1_valid,
    output logic                                    s1_card_ok,
    output ssc_order_pkg::money_t                   s1_money,
    output ssc_order_pkg::nibble_t                  s1_counts [`SSC_ITEMS],
    output ssc_order_pkg::nibble_t                  s1_prices [`SSC_ITEMS]
);

    ssc_card_pkg::card_digits_t digits;
    ssc_card_pkg::card_digits_t reduced;
    ssc_card_pkg::luhn_sum_t    luhn_sum;
    logic                       card_ok;

    // ========================================
    // Luhn check
    // ========================================

    // split card into digits, position 1 first
    always_comb begin
        for (int d = 0; d < `SSC_CARD_DIGITS; d++) begin
            digits[d] = card_num[d*`SSC_NIBBLE +: `SSC_NIBBLE];
        end
    end

    // even positions (odd index) are doubled, minus 9 from 5 up
    // result stays one nibble wide, so hex digits wrap
    always_comb begin
        for (int d = 0; d < `SSC_CARD_DIGITS; d++) begin
            if (d % 2 == 1) begin
                if (digits[d] < 4'd5) begin
                    reduced[d] = digits[d] << 1;
                end else begin
                    reduced[d] = (digits[d] << 1) - 4'd9;
                end
            end else begin
                reduced[d] = digits[d];
            end
        end
    end

    // sum of all sixteen reduced digits
    always_comb begin
        luhn_sum = '0;
        for (int d = 0; d < `SSC_CARD_DIGITS; d++) begin
            luhn_sum = luhn_sum + ssc_card_pkg::luhn_sum_t'(reduced[d]);
        end
    end

    assign card_ok = ((luhn_sum % `SSC_LUHN_MOD) == 0);

    // ========================================
    // stage register
    // ========================================

    // valid strobe, cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // payload loads only on a strobe
    // count k and price k share nibble k
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_card_ok <= card_ok;
            s1_money   <= input_money;
            for (int k = 0; k < `SSC_ITEMS; k++) begin
                s1_counts[k] <= snack_num[k*`SSC_NIBBLE +: `SSC_NIBBLE];
                s1_prices[k] <= price[k*`SSC_NIBBLE +: `SSC_NIBBLE];
            end
        end
    end

endmodule

// ==== verilog/basket_sorter.sv ====
/* stage two: eight item totals, descending bitonic sort,
   registers the sorted basket with verdict and money */
`include "ssc_defs.svh"

module basket_sorter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   s1_valid,
    input  logic                   s1_card_ok,
    input  ssc_order_pkg::money_t  s1_money,
    input  ssc_order_pkg::nibble_t s1_counts [`SSC_ITEMS],
    input  ssc_order_pkg::nibble_t s1_prices [`SSC_ITEMS],
    output logic                   s2_valid,
    output logic                   s2_card_ok,
    output ssc_order_pkg::money_t  s2_money,
    output ssc_order_pkg::basket_t s2_sorted
);

    ssc_order_pkg::basket_t totals;
    ssc_order_pkg::basket_t net;

    // ========================================
    // item totals
    // ========================================

    // widen both factors first, 15 * 15 fits in 8 bits
    always_comb begin
        for (int k = 0; k < `SSC_ITEMS; k++) begin
            totals[k] = ssc_order_pkg::item_total_t'(s1_counts[k])
                      * ssc_order_pkg::item_total_t'(s1_prices[k]);
        end
    end

    // ========================================
    // sorting network
    // ========================================

    // bitonic network for 8 inputs
    //   k = 2 : 1 layer
    //   k = 4 : 2 layers
    //   k = 8 : 3 layers
    // six compare-exchange layers in total
    // pairs inside one layer never overlap, so in-place swaps are safe
    always_comb begin
        ssc_order_pkg::item_total_t tmp;
        int                         l;
        tmp = '0;
        l   = 0;
        net = totals;
        for (int k = 2; k <= `SSC_ITEMS; k = k * 2) begin
            for (int j = k / 2; j > 0; j = j / 2) begin
                for (int i = 0; i < `SSC_ITEMS; i++) begin
                    l = i ^ j;
                    if (l > i) begin
                        // blocks with bit k clear run high to low,
                        // the others low to high
                        if (((i & k) == 0) ? (net[i] < net[l]) : (net[i] > net[l])) begin
                            tmp    = net[i];
                            net[i] = net[l];
                            net[l] = tmp;
                        end
                    end
                end
            end
        end
    end

    // ========================================
    // stage register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    // sorted basket, verdict and money move on together
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_card_ok <= s1_card_ok;
            s2_money   <= s1_money;
            s2_sorted  <= net;
        end
    end

endmodule

// ==== verilog/change_calc.sv ====
/* stage three: running sums of the sorted basket,
   longest affordable prefix and the registered change */
`include "ssc_defs.svh"

module change_calc (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   s2_valid,
    input  logic                   s2_card_ok,
    input  ssc_order_pkg::money_t  s2_money,
    input  ssc_order_pkg::basket_t s2_sorted,
    output logic                   out_valid,
    output logic                   out_card_ok,
    output ssc_order_pkg::money_t  out_change
);

    ssc_order_pkg::prefix_sum_t run_sum [`SSC_ITEMS];
    ssc_order_pkg::prefix_sum_t spent;
    ssc_order_pkg::money_t      change;

    // ========================================
    // prefix purchase
    // ========================================

    // run_sum[k] = cost of the k+1 largest totals
    always_comb begin
        ssc_order_pkg::prefix_sum_t acc;
        acc = '0;
        for (int k = 0; k < `SSC_ITEMS; k++) begin
            acc        = acc + ssc_order_pkg::prefix_sum_t'(s2_sorted[k]);
            run_sum[k] = acc;
        end
    end

    // walk the prefixes, stop at the first one over budget
    // nothing fits -> spent stays zero
    always_comb begin
        logic blocked;
        blocked = 1'b0;
        spent   = '0;
        for (int k = 0; k < `SSC_ITEMS; k++) begin
            if (!blocked && run_sum[k] <= ssc_order_pkg::prefix_sum_t'(s2_money)) begin
                spent = run_sum[k];
            end else begin
                blocked = 1'b1;
            end
        end
    end

    // bad card buys nothing
    // spent never exceeds the money, so the narrowing is exact
    assign change = s2_card_ok ? (s2_money - ssc_order_pkg::money_t'(spent)) : s2_money;

    // ========================================
    // output register
    // ========================================

    // results read zero after reset and hold between strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid   <= 1'b0;
            out_card_ok <= 1'b0;
            out_change  <= '0;
        end else begin
            out_valid <= s2_valid;
            if (s2_valid) begin
                out_card_ok <= s2_card_ok;
                out_change  <= change;
            end
        end
    end

endmodule

// ==== verilog/ssc_top.sv ====
/* top level: intake, sorter and change stages in a
   three-cycle pipeline */
`include "ssc_defs.svh"

module ssc_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    in_valid,
    input  logic [`SSC_CARD_DIGITS*`SSC_NIBBLE-1:0] card_num,
    input  ssc_order_pkg::money_t                   input_money,
    input  logic [`SSC_ITEMS*`SSC_NIBBLE-1:0]       snack_num,
    input  logic [`SSC_ITEMS*`SSC_NIBBLE-1:0]       price,
    output logic                                    out_valid,
    output logic                                    out_card_ok,
    output ssc_order_pkg::money_t                   out_change
);

    // stage one -> stage two
    logic                   s1_valid;
    logic                   s1_card_ok;
    ssc_order_pkg::money_t  s1_money;
    ssc_order_pkg::nibble_t s1_counts [`SSC_ITEMS];
    ssc_order_pkg::nibble_t s1_prices [`SSC_ITEMS];

    // stage two -> stage three
    logic                   s2_valid;
    logic                   s2_card_ok;
    ssc_order_pkg::money_t  s2_money;
    ssc_order_pkg::basket_t s2_sorted;

    // card check and unpacking
    card_intake u_card_intake (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .card_num    (card_num),
        .input_money (input_money),
        .snack_num   (snack_num),
        .price       (price),
        .s1_valid    (s1_valid),
        .s1_card_ok  (s1_card_ok),
        .s1_money    (s1_money),
        .s1_counts   (s1_counts),
        .s1_prices   (s1_prices)
    );

    // totals and descending sort
    basket_sorter u_basket_sorter (
        .clk        (clk),
        .reset      (reset),
        .s1_valid   (s1_valid),
        .s1_card_ok (s1_card_ok),
        .s1_money   (s1_money),
        .s1_counts  (s1_counts),
        .s1_prices  (s1_prices),
        .s2_valid   (s2_valid),
        .s2_card_ok (s2_card_ok),
        .s2_money   (s2_money),
        .s2_sorted  (s2_sorted)
    );

    // prefix purchase and change
    change_calc u_change_calc (
        .clk         (clk),
        .reset       (reset),
        .s2_valid    (s2_valid),
        .s2_card_ok  (s2_card_ok),
        .s2_money    (s2_money),
        .s2_sorted   (s2_sorted),
        .out_valid   (out_valid),
        .out_card_ok (out_card_ok),
        .out_change  (out_change)
    );

endmodule

// ==== tb/tb_ssc.sv ====
/* testbench for ssc_top: random transactions, a reference model
   and a scoreboard queue checked against every result */
`include "ssc_defs.svh"

module tb_ssc;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                    clk;
    logic                                    reset;
    logic                                    in_valid;
    logic [`SSC_CARD_DIGITS*`SSC_NIBBLE-1:0] card_num;
    ssc_order_pkg::money_t                   input_money;
    logic [`SSC_ITEMS*`SSC_NIBBLE-1:0]       snack_num;
    logic [`SSC_ITEMS*`SSC_NIBBLE-1:0]       price;
    logic                                    out_valid;
    logic                                    out_card_ok;
    ssc_order_pkg::money_t                   out_change;

    integer seed = 32'hd7ed_5ece;
    int     errors = 0;
    int     checked = 0;
    int     ncycle = 0;
    int     n_none = 0;
    int     n_all = 0;
    logic   timed_out = 1'b0;
    logic   after_reset = 1'b0;

    // scoreboard, one entry per transaction in flight
    logic                  exp_ok_q [$];
    ssc_order_pkg::money_t exp_change_q [$];
    int                    exp_due_q [$];
    logic                  m_ok;
    ssc_order_pkg::money_t m_change;
    int                    m_bought;

    ssc_top ssc_top_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .card_num    (card_num),
        .input_money (input_money),
        .snack_num   (snack_num),
        .price       (price),
        .out_valid   (out_valid),
        .out_card_ok (out_card_ok),
        .out_change  (out_change)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // reference model
    // ========================================

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // position 1 is the lowest nibble, even positions doubled
    function automatic int luhn_digit_sum(input logic [63:0] card);
        int s;
        int d;
        int r;
        s = 0;
        for (int p = 1; p <= `SSC_CARD_DIGITS; p++) begin
            d = int'(card[(p-1)*`SSC_NIBBLE +: `SSC_NIBBLE]);
            r = d;
            if (p % 2 == 0) begin
                r = 2 * d;
                if (d >= 5) begin
                    r = r - 9;
                end
                // reduced digit kept to one nibble, hex digits wrap
                r = r % 16;
            end
            s = s + r;
        end
        return s;
    endfunction

    // pick digit 1 so the sum lands on a multiple of ten
    function automatic logic [63:0] make_good_card(input logic [63:0] card);
        logic [63:0] c;
        int          s;
        c      = card;
        c[3:0] = 4'h0;
        s      = luhn_digit_sum(c);
        c[3:0] = 4'((`SSC_LUHN_MOD - s % `SSC_LUHN_MOD) % `SSC_LUHN_MOD);
        return c;
    endfunction

    task automatic model_result(input logic [63:0] card, input ssc_order_pkg::money_t money,
                                input logic [31:0] cnt, input logic [31:0] prc,
                                output logic ok, output ssc_order_pkg::money_t change,
                                output int bought);
        int   t [`SSC_ITEMS];
        int   tmp;
        int   acc;
        int   spent;
        logic stop;
        ok = (luhn_digit_sum(card) % `SSC_LUHN_MOD == 0);
        for (int k = 0; k < `SSC_ITEMS; k++) begin
            t[k] = int'(cnt[k*`SSC_NIBBLE +: `SSC_NIBBLE]) * int'(prc[k*`SSC_NIBBLE +: `SSC_NIBBLE]);
        end
        // plain bubble sort, largest first
        for (int i = 0; i < `SSC_ITEMS - 1; i++) begin
            for (int j = 0; j < `SSC_ITEMS - 1 - i; j++) begin
                if (t[j] < t[j+1]) begin
                    tmp    = t[j];
                    t[j]   = t[j+1];
                    t[j+1] = tmp;
                end
            end
        end
        acc    = 0;
        spent  = 0;
        bought = 0;
        stop   = 1'b0;
        for (int k = 0; k < `SSC_ITEMS; k++) begin
            acc = acc + t[k];
            if (!stop && acc <= int'(money)) begin
                spent  = acc;
                bought = k + 1;
            end else begin
                stop = 1'b1;
            end
        end
        change = ok ? ssc_order_pkg::money_t'(int'(money) - spent) : money;
    endtask

    // ========================================
    // monitor and scoreboard
    // ========================================

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        ncycle++;
        if (out_valid === 1'b1) begin
            after_reset = 1'b0;
            if (exp_due_q.size() == 0) begin
                $display("ERROR: out_valid at cycle %0d with no transaction in flight", ncycle);
                errors++;
            end else begin
                assert (exp_due_q[0] == ncycle) else begin
                    $display("ERROR: result at cycle %0d, expected at cycle %0d",
                             ncycle, exp_due_q[0]);
                    errors++;
                end
                assert (out_card_ok === exp_ok_q[0]) else begin
                    $display("FAILED out_card_ok: got %h, expected %h", out_card_ok, exp_ok_q[0]);
                    errors++;
                end
                assert (out_change === exp_change_q[0]) else begin
                    $display("FAILED out_change: got %h, expected %h", out_change, exp_change_q[0]);
                    errors++;
                end
                void'(exp_ok_q.pop_front());
                void'(exp_change_q.pop_front());
                void'(exp_due_q.pop_front());
                checked++;
            end
        end else begin
            // cleared outputs until the first result after reset
            if (after_reset) begin
                assert (out_change === '0) else begin
                    $display("FAILED out_change: got %h, expected %h after reset", out_change, 9'h0);
                    errors++;
                end
                assert (out_card_ok === 1'b0) else begin
                    $display("FAILED out_card_ok: got %h, expected %h after reset", out_card_ok, 1'b0);
                    errors++;
                end
            end
            if (exp_due_q.size() > 0 && exp_due_q[0] <= ncycle) begin
                $display("ERROR: no result at cycle %0d for a pending transaction", ncycle);
                errors++;
                void'(exp_ok_q.pop_front());
                void'(exp_change_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end
        // reset seen now clears everything still in flight
        if (reset === 1'b1) begin
            exp_ok_q.delete();
            exp_change_q.delete();
            exp_due_q.delete();
            after_reset = 1'b1;
        end else if (in_valid === 1'b1) begin
            model_result(card_num, input_money, snack_num, price, m_ok, m_change, m_bought);
            exp_ok_q.push_back(m_ok);
            exp_change_q.push_back(m_change);
            exp_due_q.push_back(ncycle + 3);
            if (m_ok && m_bought == 0) n_none++;
            if (m_ok && m_bought == `SSC_ITEMS) n_all++;
        end
    end

    // ========================================
    // stimulus
    // ========================================

    // one transaction, called right after a rising edge
    task automatic send_txn();
        logic [31:0]           r;
        logic [63:0]           card;
        logic [31:0]           cnt;
        logic [31:0]           prc;
        ssc_order_pkg::money_t money;
        r     = next_rand();
        card  = {next_rand(), next_rand()};
        cnt   = next_rand();
        prc   = next_rand();
        money = ssc_order_pkg::money_t'(r[20:12]);
        // half the cards forced good
        if (r[2]) begin
            card = make_good_card(card);
        end
        // mode 1 tight money, mode 2 cheap basket
        if (r[1:0] == 2'd1) begin
            money = ssc_order_pkg::money_t'(r[11:8]);
        end else if (r[1:0] == 2'd2) begin
            cnt = cnt & 32'h3333_3333;
            prc = prc & 32'h3333_3333;
        end
        in_valid    <= 1'b1;
        card_num    <= card;
        input_money <= money;
        snack_num   <= cnt;
        price       <= prc;
    endtask

    task automatic send_burst(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            send_txn();
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic send_with_gaps(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            send_txn();
            gap = int'(next_rand() % 32'd3);
            if (gap > 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
                repeat (gap - 1) @(posedge clk);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // two-cycle reset with a strobe inside it
    task automatic pulse_reset();
        @(posedge clk);
        reset <= 1'b1;
        send_txn();
        @(posedge clk);
        in_valid <= 1'b0;
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_due_q.size() > 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (exp_due_q.size() > 0) begin
            $display("ERROR: timeout, %0d results still missing after %0d cycles",
                     exp_due_q.size(), max_cycles);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        card_num    = '0;
        input_money = '0;
        snack_num   = '0;
        price       = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // lone transaction into an idle pipeline
        send_burst(1);
        wait_drain(10);
        if (!timed_out) begin
            send_burst(40);
            wait_drain(10);
        end
        if (!timed_out) begin
            send_with_gaps(150);
            wait_drain(10);
        end
        // reset in the middle of a stream, nothing stale may follow
        if (!timed_out) begin
            send_burst(6);
            pulse_reset();
            repeat (8) @(posedge clk);
            send_burst(40);
            wait_drain(10);
        end
        assert (n_none > 0 && n_all > 0) else begin
            $display("ERROR: stimulus missed the nothing-bought or all-bought case");
            errors++;
        end
        $display("errors: %0d, results checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/ssc_card_pkg.sv
verilog/ssc_order_pkg.sv
verilog/card_intake.sv
verilog/basket_sorter.sv
verilog/change_calc.sv
verilog/ssc_top.sv
tb/tb_ssc.sv

// ==== Makefile ====
# Verilator build and run of the snack-shopping calculator testbench

VERILATOR ?= verilator
TOP       ?= tb_ssc
FLAGS     ?=
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --assert $(FLAGS) -f compile.f --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass only when the pass line shows up in the output
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) --lint-only --timing -Wall $(FLAGS) -f compile.f --top-module ssc_top

clean:
	rm -rf $(BUILD_DIR)
